//--- Makefile
TOP = pcieLinkTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f vlog.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Regression passed$$"

lint:
	verilator --lint-only --timing -Wall --top-module pcieLink -f vlog.f

clean:
	rm -rf obj_dir

//--- hw/ltssmMain.sv
`include "pcie_defs.svh"

module ltssmMain (
    input  logic clk,
    input  logic rstN,
    input  pciePkg::lpifStateT lpStateReq,
    input  pciePkg::laneMaskT phyStatus,
    input  pciePkg::laneStatusT rxStatus,
    input  logic ts1Rcvd,
    input  logic ts2Rcvd,
    output pciePkg::txKindT txKind,
    output logic detectPulse,
    output pciePkg::laneMaskT laneMask,
    output logic rxDataEnable,
    output pciePkg::lpifStateT plStateSts,
    output logic plLinkUp
);

    localparam int CountWidth = $clog2(`TS_COUNT);
    localparam int GapWidth = $clog2(`TS_LENGTH);
    localparam int TimerWidth = $clog2(`TRAIN_TIMEOUT);

    pciePkg::ltssmStateT state;
    pciePkg::ltssmStateT nextState;
    logic [CountWidth-1:0] setCount;
    logic [GapWidth-1:0] sinceSet;
    logic [TimerWidth-1:0] timer;
    pciePkg::laneMaskT detectedLanes;
    logic training;
    logic setPulse;
    logic setsDone;
    logic timedOut;

    always_comb
    begin
        for (int lane = 0; lane < `LANES; lane++)
            detectedLanes[lane] = (rxStatus[lane] == `STATUS_DETECTED);
    end

    assign training = (state == pciePkg::stPolling) || (state == pciePkg::stConfig);
    // TS1 counts in polling, TS2 in configuration
    assign setPulse = (state == pciePkg::stPolling) ? ts1Rcvd
                    : (state == pciePkg::stConfig) && ts2Rcvd;
    assign setsDone = setPulse && (setCount == CountWidth'(`TS_COUNT - 1));
    assign timedOut = training && (timer == TimerWidth'(`TRAIN_TIMEOUT - 1));

    always_comb
    begin
        nextState = state;
        case (state)
            pciePkg::stDetect:
                if (lpStateReq == pciePkg::lpifActive)
                    nextState = pciePkg::stDetectWait;
            pciePkg::stDetectWait:
                if (|phyStatus)
                    nextState = (|detectedLanes) ? pciePkg::stPolling : pciePkg::stDetect;
            pciePkg::stPolling, pciePkg::stConfig:
                if (timedOut)
                    nextState = pciePkg::stDetect;
                else if (setsDone)
                    nextState = (state == pciePkg::stPolling) ? pciePkg::stConfig
                                                              : pciePkg::stL0;
            pciePkg::stL0:
                if (lpStateReq == pciePkg::lpifRetrain)
                    nextState = pciePkg::stPolling;
                else if (lpStateReq == pciePkg::lpifReset)
                    nextState = pciePkg::stDetect;
            default:
                nextState = pciePkg::stDetect;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= pciePkg::stDetect;
            detectPulse <= 1'b0;
            laneMask <= '0;
            setCount <= '0;
            sinceSet <= '0;
            timer <= '0;
        end
        else
        begin
            state <= nextState;
            detectPulse <= (state == pciePkg::stDetect) && (nextState == pciePkg::stDetectWait);
            if (state == pciePkg::stDetectWait && |phyStatus)
                laneMask <= detectedLanes;
            if (nextState != state || !training)
            begin
                setCount <= '0;
                sinceSet <= '0;
                timer <= '0;
            end
            else
            begin
                timer <= timer + 1'b1;
                if (setPulse)
                begin
                    setCount <= setCount + 1'b1;
                    sinceSet <= '0;
                end
                else if (sinceSet == GapWidth'(`TS_LENGTH - 1))
                    setCount <= '0;  // a set went missing, start over
                else
                    sinceSet <= sinceSet + 1'b1;
            end
        end
    end

    always_comb
    begin
        case (state)
            pciePkg::stPolling: txKind = pciePkg::txTs1;
            pciePkg::stConfig: txKind = pciePkg::txTs2;
            pciePkg::stL0: txKind = pciePkg::txData;
            default: txKind = pciePkg::txIdle;
        endcase
    end

    assign rxDataEnable = (state == pciePkg::stL0);
    assign plLinkUp = (state == pciePkg::stL0);
    assign plStateSts = (state == pciePkg::stL0) ? pciePkg::lpifActive : pciePkg::lpifReset;

    // L0 is only reached through configuration
    assert property (@(posedge clk) disable iff (!rstN)
        plLinkUp |-> (state == pciePkg::stL0)
            && $past(state inside {pciePkg::stConfig, pciePkg::stL0}));

    assert property (@(posedge clk) disable iff (!rstN)
        !(state inside {pciePkg::stDetect, pciePkg::stDetectWait}) |-> laneMask != '0);

endmodule

//--- hw/pcieLink.sv
module pcieLink (
    input  logic clk,
    input  logic rstN,
    output pciePkg::pipeTxT pipeTx,
    input  pciePkg::pipeRxT pipeRx,
    input  logic lpIrdy,
    input  pciePkg::lanesDataT lpData,
    output logic plTrdy,
    output pciePkg::lanesDataT plData,
    output logic plValid,
    input  pciePkg::lpifStateT lpStateReq,
    output pciePkg::lpifStateT plStateSts,
    output logic plLinkUp
);

    pciePkg::txKindT txKind;
    logic detectPulse;
    pciePkg::laneMaskT laneMask;
    logic rxDataEnable;
    logic ts1Rcvd;
    logic ts2Rcvd;

    ltssmMain mainLtssm (
        .clk(clk),
        .rstN(rstN),
        .lpStateReq(lpStateReq),
        .phyStatus(pipeRx.phyStatus),
        .rxStatus(pipeRx.status),
        .ts1Rcvd(ts1Rcvd),
        .ts2Rcvd(ts2Rcvd),
        .txKind(txKind),
        .detectPulse(detectPulse),
        .laneMask(laneMask),
        .rxDataEnable(rxDataEnable),
        .plStateSts(plStateSts),
        .plLinkUp(plLinkUp)
    );

    txPath tx (
        .clk(clk),
        .rstN(rstN),
        .txKind(txKind),
        .detectPulse(detectPulse),
        .laneMask(laneMask),
        .lpIrdy(lpIrdy),
        .lpData(lpData),
        .plTrdy(plTrdy),
        .pipeTx(pipeTx)
    );

    rxPath rx (
        .clk(clk),
        .rstN(rstN),
        .pipeRx(pipeRx),
        .laneMask(laneMask),
        .rxDataEnable(rxDataEnable),
        .ts1Rcvd(ts1Rcvd),
        .ts2Rcvd(ts2Rcvd),
        .plData(plData),
        .plValid(plValid)
    );

endmodule

//--- hw/pciePkg.sv
`include "pcie_defs.svh"

package pciePkg;

    typedef logic [`SYMBOL_WIDTH-1:0] symbolT;
    typedef logic [`LANES-1:0] laneMaskT;
    // lane 0 sits in the low byte
    typedef logic [`LANES*`SYMBOL_WIDTH-1:0] lanesDataT;
    typedef logic [2:0] rxStatusT;
    typedef rxStatusT [`LANES-1:0] laneStatusT;

    typedef enum logic [3:0] {
        lpifReset = 4'd0,
        lpifActive = 4'd1,
        lpifRetrain = 4'd2
    } lpifStateT;

    typedef enum logic [2:0] {stDetect, stDetectWait, stPolling, stConfig, stL0} ltssmStateT;

    typedef enum logic [1:0] {txIdle, txTs1, txTs2, txData} txKindT;

    typedef struct packed {
        lanesDataT data;
        laneMaskT dataK;
        laneMaskT dataValid;
        laneMaskT elecIdle;
        logic detectRx;
    } pipeTxT;

    typedef struct packed {
        lanesDataT data;
        laneMaskT dataK;
        laneMaskT dataValid;
        laneMaskT phyStatus;
        laneStatusT status;
    } pipeRxT;

endpackage

//--- hw/pcie_defs.svh
`ifndef PCIE_DEFS_SVH
`define PCIE_DEFS_SVH

// link geometry
`define LANES 4
`define SYMBOL_WIDTH 8

// gen1 symbol codes
`define COM_SYMBOL 8'hBC
`define PAD_SYMBOL 8'hF7
`define TS1_ID 8'h4A
`define TS2_ID 8'h45
`define LINK_NUMBER 8'd1

// set is COM, link field, lane number, identifier
`define TS_LENGTH 4
`define TS_COUNT 8
`define TRAIN_TIMEOUT 64

// PIPE RxStatus value for a present receiver
`define STATUS_DETECTED 3'b011

`endif

//--- hw/rxPath.sv
`include "pcie_defs.svh"

module rxPath (
    input  logic clk,
    input  logic rstN,
    input  pciePkg::pipeRxT pipeRx,
    input  pciePkg::laneMaskT laneMask,
    input  logic rxDataEnable,
    output logic ts1Rcvd,
    output logic ts2Rcvd,
    output pciePkg::lanesDataT plData,
    output logic plValid
);

    localparam int PosWidth = $clog2(`TS_LENGTH);

    pciePkg::laneMaskT ts1Lane;
    pciePkg::laneMaskT ts2Lane;
    logic enableQ;
    logic dataWord;

    for (genvar lane = 0; lane < `LANES; lane++)
    begin : genLane
        pciePkg::symbolT sym;
        logic symK;
        logic symValid;
        // 0 means hunting for COM
        logic [PosWidth-1:0] pos;
        logic padSeen;
        logic linkSeen;
        logic laneOk;
        logic ts1Hit;
        logic ts2Hit;

        assign sym = pipeRx.data[lane*`SYMBOL_WIDTH +: `SYMBOL_WIDTH];
        assign symK = pipeRx.dataK[lane];
        assign symValid = pipeRx.dataValid[lane];

        always_ff @(posedge clk or negedge rstN)
        begin
            if (!rstN)
            begin
                pos <= '0;
                padSeen <= 1'b0;
                linkSeen <= 1'b0;
                laneOk <= 1'b0;
                ts1Hit <= 1'b0;
                ts2Hit <= 1'b0;
            end
            else
            begin
                ts1Hit <= 1'b0;
                ts2Hit <= 1'b0;
                if (!symValid)
                    pos <= '0;
                else if (symK && sym == `COM_SYMBOL)
                    pos <= PosWidth'(1);
                else
                begin
                    case (int'(pos))
                        1:
                        begin
                            padSeen <= symK && (sym == `PAD_SYMBOL);
                            linkSeen <= !symK && (sym == `LINK_NUMBER);
                            pos <= PosWidth'(2);
                        end
                        2:
                        begin
                            laneOk <= !symK && (sym == pciePkg::symbolT'(lane));
                            pos <= PosWidth'(3);
                        end
                        `TS_LENGTH - 1:
                        begin
                            ts1Hit <= laneOk && padSeen && !symK && (sym == `TS1_ID);
                            ts2Hit <= laneOk && linkSeen && !symK && (sym == `TS2_ID);
                            pos <= '0;
                        end
                        default:
                            pos <= '0;
                    endcase
                end
            end
        end

        assign ts1Lane[lane] = ts1Hit;
        assign ts2Lane[lane] = ts2Hit;
    end

    // sets are aligned, so every detected lane flags on the same cycle
    assign ts1Rcvd = (laneMask != '0) && ((ts1Lane & laneMask) == laneMask);
    assign ts2Rcvd = (laneMask != '0) && ((ts2Lane & laneMask) == laneMask);

    // first L0 cycle still carries the tail of a TS2
    assign dataWord = rxDataEnable && enableQ && (laneMask != '0)
                    && ((pipeRx.dataValid & laneMask) == laneMask)
                    && ((pipeRx.dataK & laneMask) == '0);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            enableQ <= 1'b0;
            plValid <= 1'b0;
        end
        else
        begin
            enableQ <= rxDataEnable;
            plValid <= dataWord;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dataWord)
            plData <= pipeRx.data;
    end

    assert property (@(posedge clk) disable iff (!rstN)
        plValid |-> $past(rxDataEnable, 1) && $past(rxDataEnable, 2));

endmodule

//--- hw/txPath.sv
`include "pcie_defs.svh"

module txPath (
    input  logic clk,
    input  logic rstN,
    input  pciePkg::txKindT txKind,
    input  logic detectPulse,
    input  pciePkg::laneMaskT laneMask,
    input  logic lpIrdy,
    input  pciePkg::lanesDataT lpData,
    output logic plTrdy,
    output pciePkg::pipeTxT pipeTx
);

    localparam int PosWidth = $clog2(`TS_LENGTH);

    logic [PosWidth-1:0] pos;
    pciePkg::txKindT heldKind;
    pciePkg::txKindT setKind;
    logic training;
    logic accept;
    pciePkg::lanesDataT setData;
    pciePkg::laneMaskT setK;
    pciePkg::lanesDataT txData;
    pciePkg::laneMaskT txK;
    pciePkg::laneMaskT txValid;
    pciePkg::laneMaskT txIdle;

    assign training = (txKind == pciePkg::txTs1) || (txKind == pciePkg::txTs2);
    assign plTrdy = (txKind == pciePkg::txData);
    assign accept = plTrdy && lpIrdy;
    // a set keeps the kind it started with
    assign setKind = (pos == '0) ? txKind : heldKind;

    always_comb
    begin
        setData = '0;
        setK = '0;
        for (int lane = 0; lane < `LANES; lane++)
        begin
            case (int'(pos))
                0:
                begin
                    setData[lane*`SYMBOL_WIDTH +: `SYMBOL_WIDTH] = `COM_SYMBOL;
                    setK[lane] = 1'b1;
                end
                1:
                begin
                    setData[lane*`SYMBOL_WIDTH +: `SYMBOL_WIDTH] =
                        (setKind == pciePkg::txTs2) ? `LINK_NUMBER : `PAD_SYMBOL;
                    setK[lane] = (setKind != pciePkg::txTs2);
                end
                2:
                    setData[lane*`SYMBOL_WIDTH +: `SYMBOL_WIDTH] = pciePkg::symbolT'(lane);
                default:
                    setData[lane*`SYMBOL_WIDTH +: `SYMBOL_WIDTH] =
                        (setKind == pciePkg::txTs2) ? `TS2_ID : `TS1_ID;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pos <= '0;
            heldKind <= pciePkg::txIdle;
            txK <= '0;
            txValid <= '0;
            txIdle <= '1;
        end
        else
        begin
            txIdle <= (txKind == pciePkg::txIdle) ? '1 : ~laneMask;
            if (training)
            begin
                pos <= (pos == PosWidth'(`TS_LENGTH - 1)) ? '0 : pos + 1'b1;
                heldKind <= setKind;
                txK <= setK & laneMask;
                txValid <= laneMask;
            end
            else
            begin
                pos <= '0;
                txK <= '0;
                txValid <= accept ? laneMask : '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (training)
            txData <= setData;
        else if (accept)
            txData <= lpData;
    end

    assign pipeTx = '{data: txData, dataK: txK, dataValid: txValid,
                      elecIdle: txIdle, detectRx: detectPulse};

    // lanes that failed detection never carry symbols
    assert property (@(posedge clk) disable iff (!rstN)
        (pipeTx.dataValid & ~laneMask) == '0);

endmodule

//--- testbench/pcieLinkTb.sv
`include "pcie_defs.svh"

module pcieLinkTb;

    // limit far above the combined length of the six tests
    localparam int CycleLimit = 4000;

    logic clk;
    logic rstN;
    pciePkg::pipeTxT pipeTx;
    pciePkg::pipeRxT pipeRx;
    logic lpIrdy;
    pciePkg::lanesDataT lpData;
    logic plTrdy;
    pciePkg::lanesDataT plData;
    logic plValid;
    pciePkg::lpifStateT lpStateReq;
    pciePkg::lpifStateT plStateSts;
    logic plLinkUp;

    logic loopOn;
    pciePkg::rxStatusT statusAnswer;
    logic detectSeen = 1'b0;
    pciePkg::laneMaskT phyStatusQ = '0;
    pciePkg::laneStatusT statusQ = '0;
    int cycles = 0;
    int seed;
    string testName;
    // words in flight and the cycle each must come back on
    pciePkg::lanesDataT expWords[$];
    int expDue[$];

    pcieLink dut_i (
        .clk(clk),
        .rstN(rstN),
        .pipeTx(pipeTx),
        .pipeRx(pipeRx),
        .lpIrdy(lpIrdy),
        .lpData(lpData),
        .plTrdy(plTrdy),
        .plData(plData),
        .plValid(plValid),
        .lpStateReq(lpStateReq),
        .plStateSts(plStateSts),
        .plLinkUp(plLinkUp)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == CycleLimit)
        begin
            $display("Timeout: tests still running after %0d cycles", CycleLimit);
            $display("Regression failed");
            $fatal(1);
        end
    end

    // PHY model, answers a detect pulse one cycle later
    always @(posedge clk)
    begin
        #2;
        phyStatusQ = detectSeen ? '1 : '0;
        statusQ = detectSeen ? {`LANES{statusAnswer}} : '0;
        detectSeen = pipeTx.detectRx;
    end

    always_comb
    begin
        pipeRx.data = loopOn ? pipeTx.data : '0;
        pipeRx.dataK = loopOn ? pipeTx.dataK : '0;
        pipeRx.dataValid = loopOn ? pipeTx.dataValid : '0;
        pipeRx.phyStatus = phyStatusQ;
        pipeRx.status = statusQ;
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkBit(input string what, input logic expected, input logic actual);
        if (actual !== expected)
            stopRun($sformatf("Mismatch in %s: %s expected %b, got %b",
                              testName, what, expected, actual));
    endtask

    task automatic checkState(input string what, input pciePkg::lpifStateT expected,
                              input pciePkg::lpifStateT actual);
        if (actual !== expected)
            stopRun($sformatf("Mismatch in %s: %s expected %s, got %s",
                              testName, what, expected.name(), actual.name()));
    endtask

    task automatic checkData(input string what, input pciePkg::lanesDataT expected,
                             input pciePkg::lanesDataT actual);
        if (actual !== expected)
            stopRun($sformatf("Mismatch in %s: %s expected %h, got %h",
                              testName, what, expected, actual));
    endtask

    task automatic checkSymbol(input string what, input pciePkg::symbolT expected,
                               input pciePkg::symbolT actual);
        if (actual !== expected)
            stopRun($sformatf("Mismatch in %s: %s expected %h, got %h",
                              testName, what, expected, actual));
    endtask

    // link must stay down while detection repeats
    task automatic waitDetectPulse(input int bound);
        int waited;
        waited = 0;
        step();
        while (!pipeTx.detectRx)
        begin
            if (waited >= bound)
                stopRun($sformatf("%s: no detect pulse within %0d cycles", testName, bound));
            checkBit("plLinkUp", 1'b0, plLinkUp);
            step();
            waited++;
        end
        checkBit("plLinkUp", 1'b0, plLinkUp);
    endtask

    task automatic waitLinkUp(input int bound);
        int waited;
        waited = 0;
        while (!plLinkUp)
        begin
            if (waited >= bound)
                stopRun($sformatf("%s: link did not come up within %0d cycles",
                                  testName, bound));
            checkBit("plValid", 1'b0, plValid);
            step();
            waited++;
        end
        checkState("plStateSts", pciePkg::lpifActive, plStateSts);
    endtask

    // symbols from position first to the end of one set, all lanes aligned
    task automatic checkSetFrom(input int first, input logic isTs2);
        pciePkg::symbolT expSym;
        logic expK;
        for (int pos = first; pos < `TS_LENGTH; pos++)
        begin
            for (int lane = 0; lane < `LANES; lane++)
            begin
                case (pos)
                    0:
                    begin
                        expSym = `COM_SYMBOL;
                        expK = 1'b1;
                    end
                    1:
                    begin
                        expSym = isTs2 ? `LINK_NUMBER : `PAD_SYMBOL;
                        expK = !isTs2;
                    end
                    2:
                    begin
                        expSym = pciePkg::symbolT'(lane);
                        expK = 1'b0;
                    end
                    default:
                    begin
                        expSym = isTs2 ? `TS2_ID : `TS1_ID;
                        expK = 1'b0;
                    end
                endcase
                checkSymbol($sformatf("lane %0d symbol %0d", lane, pos), expSym,
                            pipeTx.data[lane*`SYMBOL_WIDTH +: `SYMBOL_WIDTH]);
                checkBit($sformatf("lane %0d K flag %0d", lane, pos), expK, pipeTx.dataK[lane]);
                checkBit($sformatf("lane %0d valid %0d", lane, pos), 1'b1,
                         pipeTx.dataValid[lane]);
            end
            if (pos < `TS_LENGTH - 1)
                step();
        end
    endtask

    task automatic checkReturn();
        if (plValid)
        begin
            if (expWords.size() == 0)
                stopRun($sformatf("%s: plValid with no word outstanding", testName));
            if (expDue[0] != cycles)
                stopRun($sformatf("Mismatch in %s: return cycle expected %0d, got %0d",
                                  testName, expDue[0], cycles));
            checkData("plData", expWords[0], plData);
            void'(expWords.pop_front());
            void'(expDue.pop_front());
        end
        else if (expWords.size() != 0 && expDue[0] == cycles)
            stopRun($sformatf("%s: word due on cycle %0d did not come back", testName, cycles));
    endtask

    // a driven word comes back on plData two cycles later
    task automatic sendWords(input int count);
        pciePkg::lanesDataT word;
        for (int i = 0; i < count + 6; i++)
        begin
            if (i < count)
            begin
                checkBit("plTrdy", 1'b1, plTrdy);
                word = $random(seed);
                lpIrdy = 1'b1;
                lpData = word;
                expWords.push_back(word);
                expDue.push_back(cycles + 2);
            end
            else
                lpIrdy = 1'b0;
            step();
            checkReturn();
        end
        if (expWords.size() != 0)
            stopRun($sformatf("%s: words never came back on plData", testName));
    endtask

    task automatic checkResetValues();
        testName = "reset values";
        checkBit("plLinkUp", 1'b0, plLinkUp);
        checkBit("plTrdy", 1'b0, plTrdy);
        checkBit("detectRx", 1'b0, pipeTx.detectRx);
        checkBit("plValid", 1'b0, plValid);
        for (int lane = 0; lane < `LANES; lane++)
            checkBit($sformatf("elecIdle[%0d]", lane), 1'b1, pipeTx.elecIdle[lane]);
        checkState("plStateSts", pciePkg::lpifReset, plStateSts);
    endtask

    task automatic noReceiver();
        testName = "no receiver";
        statusAnswer = 3'b000;
        loopOn = 1'b0;
        lpStateReq = pciePkg::lpifActive;
        waitDetectPulse(4);
        waitDetectPulse(4);
        repeat (200)
        begin
            step();
            checkBit("plLinkUp", 1'b0, plLinkUp);
        end
        lpStateReq = pciePkg::lpifReset;
        repeat (4) step();
    endtask

    task automatic trainLink();
        int start;
        testName = "training";
        start = cycles;
        statusAnswer = `STATUS_DETECTED;
        loopOn = 1'b1;
        lpStateReq = pciePkg::lpifActive;
        while (pipeTx.dataValid == '0)
        begin
            if (cycles - start >= 2 * `TRAIN_TIMEOUT)
                stopRun("training: no training set appeared on the lanes");
            step();
        end
        checkSetFrom(0, 1'b0);
        // lane 0 shows the link number only in the link field of a TS2
        while (pipeTx.dataK[0] || !pipeTx.dataValid[0]
               || pipeTx.data[`SYMBOL_WIDTH-1:0] != `LINK_NUMBER)
        begin
            if (cycles - start >= 2 * `TRAIN_TIMEOUT)
                stopRun("training: no TS2 with the link number was sent");
            step();
        end
        checkSetFrom(1, 1'b1);
        waitLinkUp(2 * `TRAIN_TIMEOUT - (cycles - start));
    endtask

    task automatic dataLoopback();
        testName = "data";
        sendWords(20);
    endtask

    task automatic retrain();
        testName = "retrain";
        lpStateReq = pciePkg::lpifRetrain;
        step();
        checkBit("plLinkUp", 1'b0, plLinkUp);
        checkState("plStateSts", pciePkg::lpifReset, plStateSts);
        lpStateReq = pciePkg::lpifActive;
        waitLinkUp(2 * `TRAIN_TIMEOUT);
        sendWords(5);
    endtask

    task automatic trainTimeout();
        testName = "timeout";
        lpStateReq = pciePkg::lpifReset;
        step();
        checkBit("plLinkUp", 1'b0, plLinkUp);
        loopOn = 1'b0;
        lpStateReq = pciePkg::lpifActive;
        waitDetectPulse(4);
        waitDetectPulse(`TRAIN_TIMEOUT + 10);
    endtask

    initial
    begin
        clk = 1'b0;
        rstN = 1'b0;
        lpIrdy = 1'b0;
        lpData = '0;
        lpStateReq = pciePkg::lpifReset;
        loopOn = 1'b0;
        statusAnswer = '0;
        seed = 32'h873fa2bd;
        repeat (4) @(posedge clk);
        #2;
        rstN = 1'b1;
        checkResetValues();
        noReceiver();
        trainLink();
        dataLoopback();
        retrain();
        trainTimeout();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/pciePkg.sv
hw/ltssmMain.sv
hw/txPath.sv
hw/rxPath.sv
hw/pcieLink.sv
testbench/pcieLinkTb.sv
